// File: common/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// ********************
// datapath
// ********************

// data and instruction word
`define CPU_DATA_W 16

// instruction address
`define CPU_PC_W 16

// ********************
// register file
// ********************

`define CPU_REG_CNT 8
`define CPU_REG_AW 3

// ********************
// fetch
// ********************

// first fetch address after reset
`define CPU_RESET_PC 16'h0000

`endif

// File: common/cpu_pkg.sv
`default_nettype none
`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] data_t;
    typedef logic [`CPU_PC_W-1:0]   pc_t;
    typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

    // major opcode, bits 15:11
    typedef enum logic [4:0] {
        OP_NOP   = 5'b00001,
        OP_BEQZ  = 5'b00100,
        OP_BNEZ  = 5'b00101,
        OP_ADDIU = 5'b01001,
        OP_LI    = 5'b01101,
        OP_LW    = 5'b10011,
        OP_SW    = 5'b11011,
        OP_RTYPE = 5'b11100
    } opcode_e;

    typedef enum logic [1:0] {
        FN_AND  = 2'b00,
        FN_ADDU = 2'b01,
        FN_OR   = 2'b10,
        FN_SUBU = 2'b11
    } funct_e;

    typedef enum logic [1:0] {
        ADD,
        SUB,
        AND,
        OR
    } alu_op_e;

    typedef enum logic [1:0] {
        DST_RX,
        DST_RY,
        DST_RZ
    } dest_sel_e;

    // ********************
    // instruction views
    // ********************

    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rx;
        reg_addr_t ry;
        reg_addr_t rz;
        funct_e    funct;
    } inst_r_t;

    typedef struct packed {
        opcode_e    opcode;
        reg_addr_t  rx;
        logic [7:0] imm8;
    } inst_i_t;

    typedef struct packed {
        opcode_e    opcode;
        reg_addr_t  rx;
        reg_addr_t  ry;
        logic [4:0] imm5;
    } inst_m_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_m_t m;
    } inst_u;

    // ********************
    // pipeline contents
    // ********************

    typedef struct packed {
        alu_op_e   alu_op;
        logic      a_zero;
        logic      b_is_imm;
        logic      reg_we;
        logic      mem_rd;
        logic      mem_wr;
        logic      br_zero;
        logic      br_nonzero;
        dest_sel_e dest_sel;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        pc_t       pc_next;
        reg_addr_t rs_a;
        reg_addr_t rs_b;
        data_t     rs_a_data;
        data_t     rs_b_data;
        data_t     imm;
        reg_addr_t dest;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      reg_we;
        logic      mem_rd;
        logic      mem_wr;
        reg_addr_t dest;
        data_t     result;
        data_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic  en;
        logic  we;
        data_t addr;
        data_t wdata;
    } dmem_req_t;

    // register write of the current cycle
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        data_t     data;
    } wb_t;

endpackage

`default_nettype wire

// File: decode/decoder.sv
`default_nettype none

module decoder (
    input  wire cpu_pkg::inst_u inst_i,
    output cpu_pkg::ctrl_t      ctrl_o,
    output cpu_pkg::data_t      imm_o,
    output cpu_pkg::reg_addr_t  dest_o,
    output cpu_pkg::reg_addr_t  rs_a_o,
    output cpu_pkg::reg_addr_t  rs_b_o
);

    always_comb begin
        ctrl_o = '0;
        imm_o  = '0;
        rs_a_o = inst_i.i.rx;
        rs_b_o = '0;
        case (inst_i.r.opcode)
            cpu_pkg::OP_RTYPE: begin
                ctrl_o.reg_we   = 1'b1;
                ctrl_o.dest_sel = cpu_pkg::DST_RZ;
                rs_a_o          = inst_i.r.rx;
                rs_b_o          = inst_i.r.ry;
                case (inst_i.r.funct)
                    cpu_pkg::FN_ADDU: ctrl_o.alu_op = cpu_pkg::ADD;
                    cpu_pkg::FN_SUBU: ctrl_o.alu_op = cpu_pkg::SUB;
                    cpu_pkg::FN_AND:  ctrl_o.alu_op = cpu_pkg::AND;
                    default:          ctrl_o.alu_op = cpu_pkg::OR;
                endcase
            end
            cpu_pkg::OP_ADDIU: begin
                ctrl_o.reg_we   = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
                imm_o           = cpu_pkg::data_t'($signed(inst_i.i.imm8));
            end
            cpu_pkg::OP_LI: begin
                // zero + imm
                ctrl_o.reg_we   = 1'b1;
                ctrl_o.a_zero   = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
                imm_o           = cpu_pkg::data_t'(inst_i.i.imm8);
            end
            cpu_pkg::OP_LW: begin
                ctrl_o.reg_we   = 1'b1;
                ctrl_o.mem_rd   = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.dest_sel = cpu_pkg::DST_RY;
                rs_a_o          = inst_i.m.rx;
                rs_b_o          = inst_i.m.ry;
                imm_o           = cpu_pkg::data_t'($signed(inst_i.m.imm5));
            end
            cpu_pkg::OP_SW: begin
                ctrl_o.mem_wr   = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
                rs_a_o          = inst_i.m.rx;
                rs_b_o          = inst_i.m.ry;
                imm_o           = cpu_pkg::data_t'($signed(inst_i.m.imm5));
            end
            cpu_pkg::OP_BEQZ: begin
                ctrl_o.br_zero = 1'b1;
                imm_o          = cpu_pkg::data_t'($signed(inst_i.i.imm8));
            end
            cpu_pkg::OP_BNEZ: begin
                ctrl_o.br_nonzero = 1'b1;
                imm_o             = cpu_pkg::data_t'($signed(inst_i.i.imm8));
            end
            // NOP and anything unknown
            default: ;
        endcase
    end

    always_comb begin
        case (ctrl_o.dest_sel)
            cpu_pkg::DST_RY: dest_o = inst_i.m.ry;
            cpu_pkg::DST_RZ: dest_o = inst_i.r.rz;
            default:         dest_o = inst_i.i.rx;
        endcase
    end

endmodule

`default_nettype wire

// File: decode/reg_file.sv
`default_nettype none
`include "cpu_defs.svh"

module reg_file (
    input  wire logic               clk_50MHz,
    input  wire logic               rst,
    input  wire cpu_pkg::reg_addr_t rd_a_i,
    input  wire cpu_pkg::reg_addr_t rd_b_i,
    input  wire cpu_pkg::wb_t       wb_i,
    output cpu_pkg::data_t          rd_a_data_o,
    output cpu_pkg::data_t          rd_b_data_o
);

    cpu_pkg::data_t regs [`CPU_REG_CNT];

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `CPU_REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // write-through so decode sees this cycle's write
    assign rd_a_data_o = (wb_i.valid && wb_i.addr == rd_a_i) ? wb_i.data : regs[rd_a_i];
    assign rd_b_data_o = (wb_i.valid && wb_i.addr == rd_b_i) ? wb_i.data : regs[rd_b_i];

endmodule

`default_nettype wire

// File: decode/decode_stage.sv
`default_nettype none

module decode_stage (
    input  wire logic           clk_50MHz,
    input  wire logic           rst,
    input  wire cpu_pkg::inst_u if_id_inst_i,
    input  wire logic           if_id_valid_i,
    input  wire cpu_pkg::pc_t   if_id_pc_next_i,
    input  wire logic           flush_i,
    input  wire cpu_pkg::wb_t   wb_i,
    output logic                stall_o,
    output cpu_pkg::id_ex_t     id_ex_o
);

    cpu_pkg::ctrl_t     dec_ctrl;
    cpu_pkg::data_t     dec_imm;
    cpu_pkg::reg_addr_t dec_dest;
    cpu_pkg::reg_addr_t rs_a;
    cpu_pkg::reg_addr_t rs_b;
    cpu_pkg::data_t     rs_a_data;
    cpu_pkg::data_t     rs_b_data;
    logic               uses_a;
    logic               uses_b;
    cpu_pkg::id_ex_t    id_ex_d;

    decoder decoder_i (
        .inst_i (if_id_inst_i),
        .ctrl_o (dec_ctrl),
        .imm_o  (dec_imm),
        .dest_o (dec_dest),
        .rs_a_o (rs_a),
        .rs_b_o (rs_b)
    );

    reg_file reg_file_i (
        .clk_50MHz   (clk_50MHz),
        .rst         (rst),
        .rd_a_i      (rs_a),
        .rd_b_i      (rs_b),
        .wb_i        (wb_i),
        .rd_a_data_o (rs_a_data),
        .rd_b_data_o (rs_b_data)
    );

    // ********************
    // load-use hazard
    // ********************

    // which register fields are real sources
    assign uses_a = !dec_ctrl.a_zero &&
                    (dec_ctrl.reg_we || dec_ctrl.mem_wr || dec_ctrl.br_zero || dec_ctrl.br_nonzero);
    assign uses_b = dec_ctrl.mem_wr || (dec_ctrl.reg_we && !dec_ctrl.b_is_imm);

    assign stall_o = if_id_valid_i && id_ex_o.valid && id_ex_o.ctrl.mem_rd &&
                     ((uses_a && rs_a == id_ex_o.dest) || (uses_b && rs_b == id_ex_o.dest));

    // ********************
    // ID/EX register
    // ********************

    always_comb begin
        id_ex_d.valid     = if_id_valid_i;
        id_ex_d.ctrl      = dec_ctrl;
        id_ex_d.pc_next   = if_id_pc_next_i;
        id_ex_d.rs_a      = rs_a;
        id_ex_d.rs_b      = rs_b;
        id_ex_d.rs_a_data = rs_a_data;
        id_ex_d.rs_b_data = rs_b_data;
        id_ex_d.imm       = dec_imm;
        id_ex_d.dest      = dec_dest;
    end

    // bubble on flush, stall or an empty slot
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            id_ex_o <= '0;
        end else if (flush_i || stall_o || !if_id_valid_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

// File: execute/execute_stage.sv
`default_nettype none

module execute_stage (
    input  wire logic            clk_50MHz,
    input  wire logic            rst,
    input  wire cpu_pkg::id_ex_t id_ex_i,
    input  wire cpu_pkg::wb_t    wb_i,
    output logic                 branch_taken_o,
    output cpu_pkg::pc_t         branch_target_o,
    output cpu_pkg::ex_mem_t     ex_mem_o
);

    cpu_pkg::data_t   fwd_a;
    cpu_pkg::data_t   fwd_b;
    cpu_pkg::data_t   alu_a;
    cpu_pkg::data_t   alu_b;
    cpu_pkg::data_t   alu_y;
    cpu_pkg::ex_mem_t ex_mem_d;

    // youngest producer first
    // a load in EX/MEM has no data yet, load-use stall covers it
    function automatic cpu_pkg::data_t forward(
        input cpu_pkg::reg_addr_t rs,
        input cpu_pkg::data_t     rf_data,
        input cpu_pkg::ex_mem_t   em,
        input cpu_pkg::wb_t       wb
    );
        if (em.valid && em.reg_we && !em.mem_rd && em.dest == rs) begin
            return em.result;
        end
        if (wb.valid && wb.addr == rs) begin
            return wb.data;
        end
        return rf_data;
    endfunction

    assign fwd_a = forward(id_ex_i.rs_a, id_ex_i.rs_a_data, ex_mem_o, wb_i);
    assign fwd_b = forward(id_ex_i.rs_b, id_ex_i.rs_b_data, ex_mem_o, wb_i);

    // ********************
    // ALU
    // ********************

    assign alu_a = id_ex_i.ctrl.a_zero ? '0 : fwd_a;
    assign alu_b = id_ex_i.ctrl.b_is_imm ? id_ex_i.imm : fwd_b;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            cpu_pkg::ADD: alu_y = alu_a + alu_b;
            cpu_pkg::SUB: alu_y = alu_a - alu_b;
            cpu_pkg::AND: alu_y = alu_a & alu_b;
            default:      alu_y = alu_a | alu_b;
        endcase
    end

    // ********************
    // branch resolution
    // ********************

    assign branch_taken_o = id_ex_i.valid &&
                            ((id_ex_i.ctrl.br_zero && fwd_a == '0) ||
                             (id_ex_i.ctrl.br_nonzero && fwd_a != '0));

    // offset is relative to PC+1
    assign branch_target_o = id_ex_i.pc_next + id_ex_i.imm;

    // ********************
    // EX/MEM register
    // ********************

    always_comb begin
        ex_mem_d.valid      = id_ex_i.valid;
        ex_mem_d.reg_we     = id_ex_i.valid && id_ex_i.ctrl.reg_we;
        ex_mem_d.mem_rd     = id_ex_i.valid && id_ex_i.ctrl.mem_rd;
        ex_mem_d.mem_wr     = id_ex_i.valid && id_ex_i.ctrl.mem_wr;
        ex_mem_d.dest       = id_ex_i.dest;
        ex_mem_d.result     = alu_y;
        ex_mem_d.store_data = fwd_b;
    end

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o <= ex_mem_d;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_unit.sv
`default_nettype none
`include "cpu_defs.svh"

module fetch_unit (
    input  wire logic           clk_50MHz,
    input  wire logic           rst,
    input  wire cpu_pkg::data_t inst_i,
    input  wire logic           stall_i,
    input  wire logic           flush_i,
    input  wire cpu_pkg::pc_t   branch_target_i,
    output cpu_pkg::pc_t        pc_o,
    output cpu_pkg::inst_u      if_id_inst_o,
    output logic                if_id_valid_o,
    output cpu_pkg::pc_t        if_id_pc_next_o
);

    cpu_pkg::pc_t   pc_q;
    cpu_pkg::pc_t   pc_plus1;

    assign pc_plus1 = pc_q + 1'b1;
    assign pc_o     = pc_q;

    // flush wins over stall
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            pc_q          <= `CPU_RESET_PC;
            if_id_valid_o <= 1'b0;
        end else if (flush_i) begin
            pc_q          <= branch_target_i;
            if_id_valid_o <= 1'b0;
        end else if (!stall_i) begin
            pc_q          <= pc_plus1;
            if_id_valid_o <= 1'b1;
        end
    end

    // fetched word and its return address
    always_ff @(posedge clk_50MHz) begin
        if (flush_i) begin
            if_id_inst_o <= {cpu_pkg::OP_NOP, 11'h000};
        end else if (!stall_i) begin
            if_id_inst_o    <= inst_i;
            if_id_pc_next_o <= pc_plus1;
        end
    end

endmodule

`default_nettype wire

// File: source/mem_wb_stage.sv
`default_nettype none

module mem_wb_stage (
    input  wire logic             clk_50MHz,
    input  wire logic             rst,
    input  wire cpu_pkg::ex_mem_t ex_mem_i,
    input  wire cpu_pkg::data_t   dmem_rdata_i,
    output cpu_pkg::wb_t          wb_o
);

    cpu_pkg::wb_t wb_d;

    // load data or ALU result
    always_comb begin
        wb_d.valid = ex_mem_i.valid && ex_mem_i.reg_we;
        wb_d.addr  = ex_mem_i.dest;
        wb_d.data  = ex_mem_i.mem_rd ? dmem_rdata_i : ex_mem_i.result;
    end

    // ********************
    // MEM/WB register
    // ********************

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            wb_o <= '0;
        end else begin
            wb_o <= wb_d;
        end
    end

endmodule

`default_nettype wire

// File: source/cpu_top.sv
`default_nettype none

module cpu_top (
    input  wire logic           clk_50MHz,
    input  wire logic           rst,
    input  wire cpu_pkg::data_t inst_i,
    input  wire cpu_pkg::data_t dmem_rdata_i,
    output cpu_pkg::pc_t        pc_o,
    output cpu_pkg::dmem_req_t  dmem_o,
    output cpu_pkg::wb_t        wb_o
);

    logic              stall;
    logic              branch_taken;
    cpu_pkg::pc_t      branch_target;
    cpu_pkg::inst_u    if_id_inst;
    logic              if_id_valid;
    cpu_pkg::pc_t      if_id_pc_next;
    cpu_pkg::id_ex_t   id_ex;
    cpu_pkg::ex_mem_t  ex_mem;

    fetch_unit fetch_unit_i (
        .clk_50MHz       (clk_50MHz),
        .rst             (rst),
        .inst_i          (inst_i),
        .stall_i         (stall),
        .flush_i         (branch_taken),
        .branch_target_i (branch_target),
        .pc_o            (pc_o),
        .if_id_inst_o    (if_id_inst),
        .if_id_valid_o   (if_id_valid),
        .if_id_pc_next_o (if_id_pc_next)
    );

    decode_stage decode_stage_i (
        .clk_50MHz       (clk_50MHz),
        .rst             (rst),
        .if_id_inst_i    (if_id_inst),
        .if_id_valid_i   (if_id_valid),
        .if_id_pc_next_i (if_id_pc_next),
        .flush_i         (branch_taken),
        .wb_i            (wb_o),
        .stall_o         (stall),
        .id_ex_o         (id_ex)
    );

    execute_stage execute_stage_i (
        .clk_50MHz       (clk_50MHz),
        .rst             (rst),
        .id_ex_i         (id_ex),
        .wb_i            (wb_o),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .ex_mem_o        (ex_mem)
    );

    mem_wb_stage mem_wb_stage_i (
        .clk_50MHz    (clk_50MHz),
        .rst          (rst),
        .ex_mem_i     (ex_mem),
        .dmem_rdata_i (dmem_rdata_i),
        .wb_o         (wb_o)
    );

    // data memory port straight off EX/MEM
    always_comb begin
        dmem_o.en    = ex_mem.mem_rd || ex_mem.mem_wr;
        dmem_o.we    = ex_mem.mem_wr;
        dmem_o.addr  = ex_mem.result;
        dmem_o.wdata = ex_mem.store_data;
    end

endmodule

`default_nettype wire

// File: tests/cpu_sva.sv
`default_nettype none

module cpu_sva (
    input wire logic               clk_50MHz,
    input wire logic               rst,
    input wire cpu_pkg::pc_t       pc_o,
    input wire cpu_pkg::dmem_req_t dmem_o,
    input wire cpu_pkg::wb_t       wb_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // a store is a memory request and writes no register
    we_implies_en: assert property (@(posedge clk_50MHz) disable iff (!rst)
        dmem_o.we |-> dmem_o.en ##1 !wb_o.valid)
        else $error("data memory write without enable or followed by a register write");

    // nothing has reached writeback yet
    wb_idle_after_reset: assert property (@(posedge clk_50MHz) $rose(rst) |-> !wb_o.valid)
        else $error("register write in the first cycle after reset");

    pc_known: assert property (@(posedge clk_50MHz) disable iff (!rst) !$isunknown(pc_o))
        else $error("pc_o is unknown");

endmodule

bind cpu_top cpu_sva cpu_sva_i (
    .clk_50MHz (clk_50MHz),
    .rst       (rst),
    .pc_o      (pc_o),
    .dmem_o    (dmem_o),
    .wb_o      (wb_o)
);

`default_nettype wire

// File: tests/cpu_tb.sv
`default_nettype none
`include "cpu_defs.svh"

module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_LEN     = 64;
    localparam int DMEM_DEPTH   = 32;
    localparam int CYCLE_LIMIT  = PROG_LEN * 4 + 50;
    localparam int DRAIN_CYCLES = 8;
    localparam cpu_pkg::data_t NOP_WORD = {cpu_pkg::OP_NOP, 11'h000};

    logic               clk_50MHz = 1'b0;
    logic               rst;
    cpu_pkg::data_t     inst;
    cpu_pkg::data_t     dmem_rdata;
    cpu_pkg::pc_t       pc;
    cpu_pkg::dmem_req_t dmem_req;
    cpu_pkg::wb_t       wb;

    cpu_pkg::data_t     prog [PROG_LEN];
    cpu_pkg::data_t     dmem [DMEM_DEPTH];
    cpu_pkg::wb_t       exp_wb_q [$];
    cpu_pkg::dmem_req_t exp_store_q [$];
    logic [31:0]        lcg_state = 32'hd5ce_dc12;
    int                 cycles;
    int                 quiet_cycles;

    cpu_top cpu_top_i (
        .clk_50MHz    (clk_50MHz),
        .rst          (rst),
        .inst_i       (inst),
        .dmem_rdata_i (dmem_rdata),
        .pc_o         (pc),
        .dmem_o       (dmem_req),
        .wb_o         (wb)
    );

    always #10 clk_50MHz = ~clk_50MHz;

    // ********************
    // memories
    // ********************

    // 32-word data memory, address taken modulo its depth
    assign inst       = (pc < 16'(PROG_LEN)) ? prog[pc[5:0]] : NOP_WORD;
    assign dmem_rdata = dmem[dmem_req.addr[4:0]];

    always @(posedge clk_50MHz) begin
        if (dmem_req.en && dmem_req.we) begin
            dmem[dmem_req.addr[4:0]] <= dmem_req.wdata;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic cpu_pkg::data_t fill_word(input int idx);
        return cpu_pkg::data_t'(idx * 2609) ^ 16'h5c3e;
    endfunction

    task automatic gen_program();
        logic [31:0]        r;
        cpu_pkg::reg_addr_t rx;
        cpu_pkg::reg_addr_t ry;
        cpu_pkg::reg_addr_t rz;
        for (int i = 0; i < PROG_LEN; i++) begin
            r  = next_rand();
            rx = r[23:21];
            ry = r[20:18];
            rz = r[17:15];
            case (int'(r[31:24]) % 11)
                0:       prog[i] = {cpu_pkg::OP_RTYPE, rx, ry, rz, cpu_pkg::FN_ADDU};
                1:       prog[i] = {cpu_pkg::OP_RTYPE, rx, ry, rz, cpu_pkg::FN_SUBU};
                2:       prog[i] = {cpu_pkg::OP_RTYPE, rx, ry, rz, cpu_pkg::FN_AND};
                3:       prog[i] = {cpu_pkg::OP_RTYPE, rx, ry, rz, cpu_pkg::FN_OR};
                4:       prog[i] = {cpu_pkg::OP_ADDIU, rx, r[14:7]};
                5:       prog[i] = {cpu_pkg::OP_LI, rx, r[14:7]};
                6:       prog[i] = {cpu_pkg::OP_LW, rx, ry, r[12:8]};
                7:       prog[i] = {cpu_pkg::OP_SW, rx, ry, r[12:8]};
                // forward offsets 0 to 7 only
                8:       prog[i] = {cpu_pkg::OP_BEQZ, rx, 5'b00000, r[6:4]};
                9:       prog[i] = {cpu_pkg::OP_BNEZ, rx, 5'b00000, r[6:4]};
                default: prog[i] = NOP_WORD;
            endcase
        end
    endtask

    // ********************
    // instruction-set model
    // ********************

    task automatic run_model();
        cpu_pkg::data_t     regs [`CPU_REG_CNT];
        cpu_pkg::data_t     mem [DMEM_DEPTH];
        cpu_pkg::inst_u     w;
        cpu_pkg::data_t     a;
        cpu_pkg::data_t     b;
        cpu_pkg::data_t     addr;
        cpu_pkg::wb_t       wr;
        cpu_pkg::dmem_req_t st;
        int                 mpc;
        for (int k = 0; k < `CPU_REG_CNT; k++) begin
            regs[k] = '0;
        end
        for (int k = 0; k < DMEM_DEPTH; k++) begin
            mem[k] = fill_word(k);
        end
        mpc = 0;
        while (mpc < PROG_LEN) begin
            w        = prog[mpc];
            a        = regs[w.r.rx];
            b        = regs[w.r.ry];
            addr     = a + {{11{w.m.imm5[4]}}, w.m.imm5};
            wr.valid = 1'b1;
            wr.addr  = w.i.rx;
            wr.data  = '0;
            mpc      = mpc + 1;
            case (w.r.opcode)
                cpu_pkg::OP_RTYPE: begin
                    wr.addr = w.r.rz;
                    case (w.r.funct)
                        cpu_pkg::FN_ADDU: wr.data = a + b;
                        cpu_pkg::FN_SUBU: wr.data = a - b;
                        cpu_pkg::FN_AND:  wr.data = a & b;
                        default:          wr.data = a | b;
                    endcase
                end
                cpu_pkg::OP_ADDIU: wr.data = a + {{8{w.i.imm8[7]}}, w.i.imm8};
                cpu_pkg::OP_LI:    wr.data = {8'h00, w.i.imm8};
                cpu_pkg::OP_LW: begin
                    wr.addr = w.m.ry;
                    wr.data = mem[addr[4:0]];
                end
                cpu_pkg::OP_SW: begin
                    mem[addr[4:0]] = b;
                    st             = {1'b1, 1'b1, addr, b};
                    exp_store_q.push_back(st);
                    wr.valid       = 1'b0;
                end
                cpu_pkg::OP_BEQZ, cpu_pkg::OP_BNEZ: begin
                    if ((a == '0) == (w.r.opcode == cpu_pkg::OP_BEQZ)) begin
                        mpc = mpc + int'($signed(w.i.imm8));
                    end
                    wr.valid = 1'b0;
                end
                default: wr.valid = 1'b0;
            endcase
            if (wr.valid) begin
                regs[wr.addr] = wr.data;
                exp_wb_q.push_back(wr);
            end
        end
    endtask

    // ********************
    // checks
    // ********************

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_wb(input cpu_pkg::wb_t got, input cpu_pkg::wb_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL wb_o got valid=%h addr=%h data=%h, exp valid=%h addr=%h data=%h",
                                got.valid, got.addr, got.data, exp.valid, exp.addr, exp.data));
        end
    endtask

    task automatic check_store(input cpu_pkg::dmem_req_t got, input cpu_pkg::dmem_req_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL dmem_o got en=%h we=%h addr=%h wdata=%h, exp %h %h %h %h",
                                got.en, got.we, got.addr, got.wdata,
                                exp.en, exp.we, exp.addr, exp.wdata));
        end
    endtask

    task automatic check_pc(input cpu_pkg::pc_t got, input cpu_pkg::pc_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL pc_o got %h expected %h", got, exp));
        end
    endtask

    initial begin
        rst <= 1'b0;
        for (int k = 0; k < DMEM_DEPTH; k++) begin
            dmem[k] <= fill_word(k);
        end
        gen_program();
        run_model();
        repeat (2) @(posedge clk_50MHz);
        rst <= 1'b1;
        @(posedge clk_50MHz);
        // outputs still hold their reset state here
        check_pc(pc, `CPU_RESET_PC);
        check_wb(wb, '0);
        check_store(dmem_req, '0);
        cycles       = 0;
        quiet_cycles = 0;
        while (quiet_cycles < DRAIN_CYCLES) begin
            @(posedge clk_50MHz);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                abort_run("timeout: the program did not drain within the cycle limit");
            end
            if (wb.valid) begin
                if (exp_wb_q.size() == 0) begin
                    abort_run("a register write appeared that the model does not expect");
                end
                check_wb(wb, exp_wb_q.pop_front());
            end
            if (dmem_req.en && dmem_req.we) begin
                if (exp_store_q.size() == 0) begin
                    abort_run("a store appeared that the model does not expect");
                end
                check_store(dmem_req, exp_store_q.pop_front());
            end
            if (exp_wb_q.size() == 0 && exp_store_q.size() == 0 && pc >= 16'(PROG_LEN)) begin
                quiet_cycles++;
            end else begin
                quiet_cycles = 0;
            end
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+common
common/cpu_pkg.sv
decode/decoder.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
source/fetch_unit.sv
source/mem_wb_stage.sv
source/cpu_top.sv
tests/cpu_sva.sv
tests/cpu_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb \
    -Mdir obj_dir -f sources.f || exit 1
out=$(./obj_dir/Vcpu_tb 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '** PASS **' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
